//--- sc1_pkg.sv
// ==============================
// sc1 shared definitions: opcodes, addressing modes,
// instruction field positions, register roles, widths
// ==============================
package sc1_pkg;

  // default widths
  localparam int INST_W  = 32;
  localparam int DATA_W  = 32;
  localparam int IADDR_W = 8;
  localparam int DADDR_W = 8;
  localparam int REG_AW  = 4;

  // field widths
  localparam int OP_W   = 7;
  localparam int IMS_W  = 5;
  localparam int OFS_W  = 6;
  localparam int IM16_W = 16;

  // bit 6 of the opcode marks the normal type
  localparam int OP_NORMAL_BIT = 6;

  typedef enum logic [OP_W-1:0] {
    OP_HALT = 7'h00,
    OP_NOP  = 7'h01,
    OP_MV   = 7'h02,
    OP_MVI  = 7'h03,
    OP_MVIH = 7'h04,
    OP_CEQ  = 7'h05,
    OP_CGT  = 7'h06,
    OP_CGTA = 7'h07,
    OP_ADD  = 7'h40,
    OP_SUB  = 7'h41,
    OP_AND  = 7'h42,
    OP_OR   = 7'h43,
    OP_XOR  = 7'h44,
    OP_NOT  = 7'h45,
    OP_SR   = 7'h46,
    OP_SL   = 7'h47,
    OP_SRA  = 7'h48
  } opcode_t;

  // raw values 2 and 3 decode as indirect
  typedef enum logic [1:0] {
    MODE_REG = 2'd0,
    MODE_IND = 2'd1
  } addr_mode_t;

  // instruction field positions
  localparam int F_OP_LO     = 0;
  localparam int F_MODE_D_LO = 11;
  localparam int F_MODE_A_LO = 9;
  localparam int F_MODE_B_LO = 7;
  localparam int F_REG_D_LO  = 26;
  localparam int F_REG_A_LO  = 20;
  localparam int F_REG_B_LO  = 14;
  localparam int F_IMSEL_A   = 25;
  localparam int F_IMSEL_B   = 19;
  localparam int F_IMS_A_LO  = 20;
  localparam int F_IMS_B_LO  = 14;
  localparam int F_IM16_LO   = 16;

  // register roles
  localparam int REG_IMM  = 0;
  localparam int REG_COND = 1;

  localparam logic [INST_W-1:0] NOP_WORD = INST_W'(OP_NOP);

endpackage

//--- sc1_exec_if.sv
// ==============================
// stage-2 decoded instruction fields
// ==============================
`timescale 1ns/10ps

interface sc1_exec_if import sc1_pkg::*; ();

  opcode_t           op;
  addr_mode_t        mode_d;
  addr_mode_t        mode_a;
  addr_mode_t        mode_b;
  logic [REG_AW-1:0] reg_d;
  logic [REG_AW-1:0] reg_a;
  logic [REG_AW-1:0] reg_b;
  // operand is the small immediate, not the register
  logic              imm_a_sel;
  logic              imm_b_sel;
  logic [IMS_W-1:0]  ims_a;
  logic [IMS_W-1:0]  ims_b;
  logic [IM16_W-1:0] im16;

  modport fetch_mp (
    output op, mode_d, mode_a, mode_b, reg_d, reg_a, reg_b,
    output imm_a_sel, imm_b_sel, ims_a, ims_b, im16
  );

  modport exec_mp (
    input op, mode_d, mode_a, mode_b, reg_d, reg_a, reg_b,
    input imm_a_sel, imm_b_sel, ims_a, ims_b, im16
  );

  // write enable only needs the op and destination mode
  modport addr_mp (
    input op, mode_d
  );

endinterface

//--- sc1_fetch.sv
// ==============================
// program counter, stop/resume control,
// instruction pipeline and field decode
// ==============================
`timescale 1ns/10ps

module sc1_fetch import sc1_pkg::*; #(
  parameter int IADDR_W = sc1_pkg::IADDR_W
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               resume,
  input  logic [INST_W-1:0]  mem_i_r,
  output logic [IADDR_W-1:0] mem_i_addr_r,
  output logic               stopped,
  output logic [REG_AW-1:0]  s1_reg_d,
  output logic [REG_AW-1:0]  s1_reg_a,
  output logic [REG_AW-1:0]  s1_reg_b,
  output addr_mode_t         s1_mode_d,
  output addr_mode_t         s1_mode_a,
  output addr_mode_t         s1_mode_b,
  output logic [OFS_W-1:0]   s1_ims_d,
  output logic               s1_valid,
  sc1_exec_if.fetch_mp       exec
);

  logic [INST_W-1:0] inst_s1;
  logic [INST_W-1:0] inst_d1;
  logic [INST_W-1:0] inst_d2;
  logic              resume_d1;
  logic              resume_pulse;
  logic              req_stop;
  logic              req_stop_d1;
  logic              stopping;
  logic              pc_hold;

  // unknown opcodes run as NOP
  function automatic opcode_t decode_op(input logic [OP_W-1:0] raw);
    opcode_t op;
    case (raw)
      OP_HALT, OP_NOP, OP_MV, OP_MVI, OP_MVIH, OP_CEQ, OP_CGT, OP_CGTA,
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SR, OP_SL, OP_SRA:
        op = opcode_t'(raw);
      default:
        op = OP_NOP;
    endcase
    return op;
  endfunction

  function automatic addr_mode_t to_mode(input logic [1:0] raw);
    return (raw == 2'd0) ? MODE_REG : MODE_IND;
  endfunction

  assign stopping     = req_stop | req_stop_d1;
  assign resume_pulse = resume & ~resume_d1;
  assign pc_hold      = stopping | (exec.op == OP_HALT);
  assign inst_s1      = (stopped || stopping) ? NOP_WORD : mem_i_r;

  // stage 1 fields
  assign s1_reg_d  = inst_s1[F_REG_D_LO +: REG_AW];
  assign s1_reg_a  = inst_s1[F_REG_A_LO +: REG_AW];
  assign s1_reg_b  = inst_s1[F_REG_B_LO +: REG_AW];
  assign s1_mode_d = to_mode(inst_s1[F_MODE_D_LO +: 2]);
  assign s1_mode_a = to_mode(inst_s1[F_MODE_A_LO +: 2]);
  assign s1_mode_b = to_mode(inst_s1[F_MODE_B_LO +: 2]);
  assign s1_ims_d  = inst_s1[F_REG_D_LO +: OFS_W];
  assign s1_valid  = ~stopped;

  // stage 2 fields
  assign exec.op        = decode_op(inst_d2[F_OP_LO +: OP_W]);
  assign exec.mode_d    = to_mode(inst_d2[F_MODE_D_LO +: 2]);
  assign exec.mode_a    = to_mode(inst_d2[F_MODE_A_LO +: 2]);
  assign exec.mode_b    = to_mode(inst_d2[F_MODE_B_LO +: 2]);
  assign exec.reg_d     = inst_d2[F_REG_D_LO +: REG_AW];
  assign exec.reg_a     = inst_d2[F_REG_A_LO +: REG_AW];
  assign exec.reg_b     = inst_d2[F_REG_B_LO +: REG_AW];
  assign exec.imm_a_sel = inst_d2[F_IMSEL_A];
  assign exec.imm_b_sel = inst_d2[F_IMSEL_B];
  assign exec.ims_a     = inst_d2[F_IMS_A_LO +: IMS_W];
  assign exec.ims_b     = inst_d2[F_IMS_B_LO +: IMS_W];
  assign exec.im16      = inst_d2[F_IM16_LO +: IM16_W];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem_i_addr_r <= '0;
      stopped      <= 1'b1;
      req_stop     <= 1'b0;
      req_stop_d1  <= 1'b0;
      resume_d1    <= 1'b0;
      inst_d1      <= NOP_WORD;
      inst_d2      <= NOP_WORD;
    end
    else
    begin
      resume_d1 <= resume;
      inst_d1   <= inst_s1;
      inst_d2   <= inst_d1;
      // one-cycle request; the two shadow slots still run
      req_stop    <= (exec.op == OP_HALT) & ~stopping & ~stopped;
      req_stop_d1 <= req_stop;
      if (stopped)
      begin
        if (resume_pulse)
        begin
          stopped      <= 1'b0;
          mem_i_addr_r <= mem_i_addr_r + IADDR_W'(1);
        end
      end
      else
      begin
        if (req_stop_d1)
          stopped <= 1'b1;
        if (!pc_hold)
          mem_i_addr_r <= mem_i_addr_r + IADDR_W'(1);
      end
    end
  end

endmodule

//--- sc1_regfile.sv
// ==============================
// 16-entry register file, condition flag
// ==============================
`timescale 1ns/10ps

module sc1_regfile import sc1_pkg::*; #(
  parameter int DATA_W = sc1_pkg::DATA_W
) (
  input  logic              clk,
  // stage 1 reads for address generation
  input  logic [REG_AW-1:0] addr_rd_d,
  input  logic [REG_AW-1:0] addr_rd_a,
  input  logic [REG_AW-1:0] addr_rd_b,
  output logic [DATA_W-1:0] addr_val_d,
  output logic [DATA_W-1:0] addr_val_a,
  output logic [DATA_W-1:0] addr_val_b,
  // stage 2 operand reads
  input  logic [REG_AW-1:0] src_rd_a,
  input  logic [REG_AW-1:0] src_rd_b,
  output logic [DATA_W-1:0] src_val_a,
  output logic [DATA_W-1:0] src_val_b,
  output logic              cond,
  input  logic              wr_en,
  input  logic [REG_AW-1:0] wr_addr,
  input  logic [DATA_W-1:0] wr_data
);

  logic [DATA_W-1:0] regs [2**REG_AW];

  assign addr_val_d = regs[addr_rd_d];
  assign addr_val_a = regs[addr_rd_a];
  assign addr_val_b = regs[addr_rd_b];
  assign src_val_a  = regs[src_rd_a];
  assign src_val_b  = regs[src_rd_b];

  // any non-zero value counts as true
  assign cond = |regs[REG_COND];

  always_ff @(posedge clk)
  begin
    if (wr_en)
      regs[wr_addr] <= wr_data;
  end

endmodule

//--- sc1_addr_gen.sv
// ==============================
// data memory addresses, write enable
// ==============================
`timescale 1ns/10ps

module sc1_addr_gen import sc1_pkg::*; #(
  parameter int DATA_W  = sc1_pkg::DATA_W,
  parameter int DADDR_W = sc1_pkg::DADDR_W
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               s1_valid,
  input  addr_mode_t         s1_mode_d,
  input  addr_mode_t         s1_mode_a,
  input  addr_mode_t         s1_mode_b,
  input  logic [DATA_W-1:0]  addr_val_d,
  input  logic [DATA_W-1:0]  addr_val_a,
  input  logic [DATA_W-1:0]  addr_val_b,
  input  logic               cond,
  sc1_exec_if.addr_mp        exec,
  output logic [DADDR_W-1:0] mem_d_addr_r_a,
  output logic [DADDR_W-1:0] mem_d_addr_r_b,
  output logic [DADDR_W-1:0] mem_d_addr_w,
  output logic               mem_d_we
);

  logic [DADDR_W-1:0] waddr_d0;
  logic [DADDR_W-1:0] waddr_d1;
  logic               we_s2;

  // normal ops always store, MV only when cond holds
  assign we_s2 = (exec.mode_d == MODE_IND) &&
                 (exec.op[OP_NORMAL_BIT] || ((exec.op == OP_MV) && cond));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      waddr_d0       <= '0;
      waddr_d1       <= '0;
      mem_d_addr_w   <= '0;
      mem_d_addr_r_a <= '0;
      mem_d_addr_r_b <= '0;
      mem_d_we       <= 1'b0;
    end
    else
    begin
      mem_d_we <= we_s2;
      // write address follows the instruction to the end of execute
      waddr_d1     <= waddr_d0;
      mem_d_addr_w <= waddr_d1;
      if (s1_valid)
      begin
        // register mode keeps the previous address
        if (s1_mode_d == MODE_IND)
          waddr_d0 <= DADDR_W'(addr_val_d);
        if (s1_mode_a == MODE_IND)
          mem_d_addr_r_a <= DADDR_W'(addr_val_a);
        if (s1_mode_b == MODE_IND)
          mem_d_addr_r_b <= DADDR_W'(addr_val_b);
      end
    end
  end

endmodule

//--- sc1_execute.sv
// ==============================
// operand select, ALU, compares,
// register write-back, memory write data
// ==============================
`timescale 1ns/10ps

module sc1_execute import sc1_pkg::*; #(
  parameter int DATA_W = sc1_pkg::DATA_W
) (
  input  logic              clk,
  input  logic              rst,
  sc1_exec_if.exec_mp       exec,
  input  logic [DATA_W-1:0] src_val_a,
  input  logic [DATA_W-1:0] src_val_b,
  input  logic              cond,
  input  logic [DATA_W-1:0] mem_d_r_a,
  input  logic [DATA_W-1:0] mem_d_r_b,
  output logic [REG_AW-1:0] src_rd_a,
  output logic [REG_AW-1:0] src_rd_b,
  output logic              wr_en,
  output logic [REG_AW-1:0] wr_addr,
  output logic [DATA_W-1:0] wr_data,
  output logic [DATA_W-1:0] mem_d_w
);

  logic [DATA_W-1:0] opnd_a;
  logic [DATA_W-1:0] opnd_b;
  logic [DATA_W-1:0] alu_out;
  logic [DATA_W-1:0] mvih_val;

  // MVIH reads r0 through port a to keep its low half
  assign src_rd_a = (exec.op == OP_MVIH) ? REG_AW'(REG_IMM) : exec.reg_a;
  assign src_rd_b = exec.reg_b;

  assign mvih_val = (src_val_a & ~(DATA_W'({IM16_W{1'b1}}) << IM16_W)) |
                    (DATA_W'(exec.im16) << IM16_W);

  always_comb
  begin
    if (exec.mode_a == MODE_IND)
      opnd_a = mem_d_r_a;
    else if (exec.imm_a_sel)
      opnd_a = DATA_W'($signed(exec.ims_a));
    else
      opnd_a = src_val_a;
    if (exec.mode_b == MODE_IND)
      opnd_b = mem_d_r_b;
    else if (exec.imm_b_sel)
      opnd_b = DATA_W'($signed(exec.ims_b));
    else
      opnd_b = src_val_b;
  end

  always_comb
  begin
    case (exec.op)
      OP_ADD:  alu_out = opnd_a + opnd_b;
      OP_SUB:  alu_out = opnd_a - opnd_b;
      OP_AND:  alu_out = opnd_a & opnd_b;
      OP_OR:   alu_out = opnd_a | opnd_b;
      OP_XOR:  alu_out = opnd_a ^ opnd_b;
      OP_NOT:  alu_out = ~opnd_a;
      OP_SR:   alu_out = opnd_a >> opnd_b;
      OP_SL:   alu_out = opnd_a << opnd_b;
      OP_SRA:  alu_out = DATA_W'($signed(opnd_a) >>> opnd_b);
      default: alu_out = '0;
    endcase
  end

  // register write port
  always_comb
  begin
    wr_en   = 1'b0;
    wr_addr = exec.reg_d;
    wr_data = alu_out;
    if (exec.op[OP_NORMAL_BIT])
      wr_en = (exec.mode_d == MODE_REG);
    else
    begin
      case (exec.op)
        OP_MV:
        begin
          wr_en   = cond && (exec.mode_d == MODE_REG);
          wr_data = opnd_a;
        end
        OP_MVI:
        begin
          wr_en   = 1'b1;
          wr_addr = REG_AW'(REG_IMM);
          wr_data = DATA_W'(exec.im16);
        end
        OP_MVIH:
        begin
          wr_en   = 1'b1;
          wr_addr = REG_AW'(REG_IMM);
          wr_data = mvih_val;
        end
        // compares give all ones or zero
        OP_CEQ, OP_CGT, OP_CGTA:
        begin
          wr_en   = 1'b1;
          wr_addr = REG_AW'(REG_COND);
          if (exec.op == OP_CEQ)
            wr_data = {DATA_W{opnd_a == opnd_b}};
          else if (exec.op == OP_CGT)
            wr_data = {DATA_W{opnd_a > opnd_b}};
          else
            wr_data = {DATA_W{$signed(opnd_a) > $signed(opnd_b)}};
        end
        default: ;
      endcase
    end
  end

  // store data, qualified by mem_d_we at the memory
  always_ff @(posedge clk)
  begin
    if (rst)
      mem_d_w <= '0;
    else if (exec.mode_d == MODE_IND)
      mem_d_w <= (exec.op == OP_MV) ? opnd_a : alu_out;
  end

endmodule

//--- sc1_cpu.sv
// ==============================
// sc1 processor top level
// ==============================
`timescale 1ns/10ps

module sc1_cpu import sc1_pkg::*; #(
  parameter int DATA_W  = sc1_pkg::DATA_W,
  parameter int IADDR_W = sc1_pkg::IADDR_W,
  parameter int DADDR_W = sc1_pkg::DADDR_W
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               resume,
  input  logic [INST_W-1:0]  mem_i_r,
  input  logic [DATA_W-1:0]  mem_d_r_a,
  input  logic [DATA_W-1:0]  mem_d_r_b,
  output logic [IADDR_W-1:0] mem_i_addr_r,
  output logic [DADDR_W-1:0] mem_d_addr_r_a,
  output logic [DADDR_W-1:0] mem_d_addr_r_b,
  output logic [DADDR_W-1:0] mem_d_addr_w,
  output logic [DATA_W-1:0]  mem_d_w,
  output logic               mem_d_we,
  output logic               stopped
);

  logic [REG_AW-1:0] s1_reg_d, s1_reg_a, s1_reg_b;
  addr_mode_t        s1_mode_d, s1_mode_a, s1_mode_b;
  logic              s1_valid;
  logic [DATA_W-1:0] addr_val_d, addr_val_a, addr_val_b;
  logic [REG_AW-1:0] src_rd_a, src_rd_b;
  logic [DATA_W-1:0] src_val_a, src_val_b;
  logic              cond;
  logic              wr_en;
  logic [REG_AW-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;

  sc1_exec_if exec_bus ();

  // displacement field has no user with modes 0 and 1
  sc1_fetch #(.IADDR_W(IADDR_W)) u_fetch (
    .clk, .rst, .resume, .mem_i_r, .mem_i_addr_r, .stopped,
    .s1_reg_d, .s1_reg_a, .s1_reg_b, .s1_mode_d, .s1_mode_a, .s1_mode_b,
    .s1_ims_d(), .s1_valid, .exec(exec_bus.fetch_mp)
  );

  sc1_regfile #(.DATA_W(DATA_W)) u_regfile (
    .clk,
    .addr_rd_d(s1_reg_d), .addr_rd_a(s1_reg_a), .addr_rd_b(s1_reg_b),
    .addr_val_d, .addr_val_a, .addr_val_b,
    .src_rd_a, .src_rd_b, .src_val_a, .src_val_b,
    .cond, .wr_en, .wr_addr, .wr_data
  );

  sc1_addr_gen #(.DATA_W(DATA_W), .DADDR_W(DADDR_W)) u_addr_gen (
    .clk, .rst, .s1_valid, .s1_mode_d, .s1_mode_a, .s1_mode_b,
    .addr_val_d, .addr_val_a, .addr_val_b, .cond,
    .exec(exec_bus.addr_mp),
    .mem_d_addr_r_a, .mem_d_addr_r_b, .mem_d_addr_w, .mem_d_we
  );

  sc1_execute #(.DATA_W(DATA_W)) u_execute (
    .clk, .rst, .exec(exec_bus.exec_mp),
    .src_val_a, .src_val_b, .cond, .mem_d_r_a, .mem_d_r_b,
    .src_rd_a, .src_rd_b, .wr_en, .wr_addr, .wr_data, .mem_d_w
  );

endmodule

//--- sc1_assert.sv
// ==============================
// port assertions for sc1_cpu, bound in
// ==============================
`timescale 1ns/10ps

module sc1_assert #(
  parameter int DATA_W  = 32,
  parameter int IADDR_W = 8,
  parameter int DADDR_W = 8
) (
  input logic               clk,
  input logic               rst,
  input logic               resume,
  input logic               stopped,
  input logic               mem_d_we,
  input logic [IADDR_W-1:0] mem_i_addr_r,
  input logic [DADDR_W-1:0] mem_d_addr_r_a,
  input logic [DADDR_W-1:0] mem_d_addr_r_b,
  input logic [DADDR_W-1:0] mem_d_addr_w,
  input logic [DATA_W-1:0]  mem_d_w
);

  // no stores once the core has settled in the stopped state
  assert property (@(posedge clk) disable iff (rst)
    (stopped && $past(stopped)) |-> !mem_d_we)
    else $error("data write while stopped");

  assert property (@(posedge clk) disable iff (rst)
    !$isunknown({stopped, mem_d_we, mem_i_addr_r, mem_d_addr_r_a,
                 mem_d_addr_r_b, mem_d_addr_w, mem_d_w}))
    else $error("unknown value on an output");

  // resume edge seen one clock before stopped falls
  assert property (@(posedge clk) disable iff (rst)
    $fell(stopped) |-> ($past(resume) && !$past(resume, 2)))
    else $error("stopped fell without a resume edge");

endmodule

bind sc1_cpu sc1_assert #(
  .DATA_W(DATA_W), .IADDR_W(IADDR_W), .DADDR_W(DADDR_W)
) u_assert (
  .clk, .rst, .resume, .stopped, .mem_d_we, .mem_i_addr_r,
  .mem_d_addr_r_a, .mem_d_addr_r_b, .mem_d_addr_w, .mem_d_w
);

//--- tb_sc1.sv
// ==============================
// sc1 testbench: memory models, program builder,
// stimulus table and result checks
// ==============================
`timescale 1ns/10ps

module tb_sc1 import sc1_pkg::*; ();

  localparam int RUN_LIMIT = 2000;
  localparam int N_ENTRIES = 17;

  typedef struct packed {
    logic [6:0] op;
    logic       a_ind;
    logic       b_ind;
    logic       b_imm;
    logic       b_eq;
    logic       sign_mix;
    logic [7:0] daddr;
  } entry_t;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        resume = 1'b0;
  logic [31:0] mem_i_r = '0;
  logic [31:0] mem_d_r_a = '0;
  logic [31:0] mem_d_r_b = '0;
  logic [7:0]  mem_i_addr_r;
  logic [7:0]  mem_d_addr_r_a;
  logic [7:0]  mem_d_addr_r_b;
  logic [7:0]  mem_d_addr_w;
  logic [31:0] mem_d_w;
  logic        mem_d_we;
  logic        stopped;

  logic [31:0] rom [256];
  logic [31:0] ram [256];
  int          write_count = 0;
  logic [31:0] lcg_state = 32'd90547;
  logic [7:0]  wp;
  entry_t      table_q [N_ENTRIES];

  sc1_cpu dut0 (.*);

  initial forever #5 clk = ~clk;

  // synchronous ROM and RAM, one clock read latency
  always @(posedge clk)
  begin
    mem_i_r   <= rom[mem_i_addr_r];
    mem_d_r_a <= ram[mem_d_addr_r_a];
    mem_d_r_b <= ram[mem_d_addr_r_b];
    // reads above still see the old word
    if (mem_d_we)
    begin
      ram[mem_d_addr_w] = mem_d_w;
      write_count       <= write_count + 1;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] fill(input logic [7:0] x);
    return {~x, x, x ^ 8'hA5, x};
  endfunction

  task automatic abort(input string msg);
    $display("** FAIL **");
    $fatal(1, "%s", msg);
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp)
    begin
      $display("Mismatch at time %0t: %s got %h expected %h", $time, msg, got, exp);
      abort("value mismatch");
    end
  endtask

  // expected results straight from the operation rules
  function automatic logic [31:0] alu_ref(input logic [6:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [31:0] r;
    case (op)
      OP_ADD: r = a + b;
      OP_SUB: r = a - b;
      OP_AND: r = a & b;
      OP_OR:  r = a | b;
      OP_XOR: r = a ^ b;
      OP_NOT: r = ~a;
      OP_SR:  r = (b > 31) ? 32'd0 : a >> b[4:0];
      OP_SL:  r = (b > 31) ? 32'd0 : a << b[4:0];
      OP_SRA: r = (b > 31) ? {32{a[31]}} : 32'($signed(a) >>> b[4:0]);
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic cmp_ref(input logic [6:0] op, input logic [31:0] a,
                                   input logic [31:0] b);
    if (op == OP_CEQ)
      return a == b;
    else if (op == OP_CGT)
      return a > b;
    return $signed(a) > $signed(b);
  endfunction

  function automatic logic [31:0] enc(input logic [6:0] op, input logic [1:0] md,
                                      input logic [1:0] ma, input logic [1:0] mb,
                                      input logic [3:0] rd, input logic [3:0] ra,
                                      input logic [3:0] rb);
    logic [31:0] w;
    w = '0;
    w[6:0]   = op;
    w[12:11] = md;
    w[10:9]  = ma;
    w[8:7]   = mb;
    w[29:26] = rd;
    w[23:20] = ra;
    w[17:14] = rb;
    return w;
  endfunction

  function automatic logic [31:0] enc_im16(input logic [6:0] op, input logic [15:0] imm);
    logic [31:0] w;
    w = '0;
    w[31:16] = imm;
    w[6:0]   = op;
    return w;
  endfunction

  task automatic put(input logic [31:0] word);
    rom[wp] = word;
    wp = wp + 8'd1;
  endtask

  // two NOPs keep a register result three slots ahead of its reader
  task automatic gap();
    put(NOP_WORD);
    put(NOP_WORD);
  endtask

  task automatic load_reg(input logic [3:0] rd, input logic [31:0] val);
    put(enc_im16(OP_MVI, val[15:0]));
    gap();
    put(enc_im16(OP_MVIH, val[31:16]));
    gap();
    put(enc(OP_MV, 2'd0, 2'd0, 2'd0, rd, 4'd0, 4'd0));
    gap();
  endtask

  task automatic wait_run();
    int n;
    n = 0;
    while (stopped)
    begin
      @(negedge clk);
      n++;
      if (n > 10)
        abort("timeout: core did not leave the stopped state after resume");
    end
    n = 0;
    while (!stopped)
    begin
      @(negedge clk);
      n++;
      if (n > RUN_LIMIT)
        abort("timeout: program did not reach HALT");
    end
  endtask

  task automatic run_entry(input entry_t e);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] bv;
    logic [31:0] w;
    logic [31:0] exp;
    logic [31:0] exp_writes;
    logic        c;
    int          count0;
    a = lcg_next();
    b = lcg_next();
    if (e.op == OP_SR || e.op == OP_SL || e.op == OP_SRA)
      b = b & 32'd31;
    if (e.b_eq)
      b = a;
    if (e.sign_mix)
    begin
      a[31] = 1'b1;
      b[31] = 1'b0;
    end
    if (e.b_imm)
      b[4] = 1'b1;
    bv = e.b_imm ? {{27{b[4]}}, b[4:0]} : b;
    ram[e.daddr] = fill(e.daddr);
    if (e.a_ind)
      ram[e.daddr + 8'd1] = a;
    if (e.b_ind)
      ram[e.daddr + 8'd2] = b;
    // the next program starts where the stopped PC points
    wp = mem_i_addr_r;
    w = enc(OP_CEQ, 2'd0, 2'd0, 2'd0, 4'd0, 4'd0, 4'd0);
    w[25] = 1'b1;
    w[19] = 1'b1;
    put(w);
    gap();
    load_reg(4'd2, a);
    load_reg(4'd3, b);
    load_reg(4'd4, {24'd0, e.daddr});
    if (e.a_ind)
      load_reg(4'd5, {24'd0, e.daddr + 8'd1});
    if (e.b_ind)
      load_reg(4'd6, {24'd0, e.daddr + 8'd2});
    if (e.op[6])
    begin
      w = enc(e.op, 2'd1, e.a_ind ? 2'd1 : 2'd0, e.b_ind ? 2'd1 : 2'd0, 4'd4,
              e.a_ind ? 4'd5 : 4'd2, e.b_ind ? 4'd6 : 4'd3);
      if (e.b_imm)
      begin
        w[19]    = 1'b1;
        w[18:14] = b[4:0];
      end
      put(w);
      gap();
      exp        = alu_ref(e.op, a, bv);
      exp_writes = 32'd1;
    end
    else
    begin
      put(enc(e.op, 2'd0, 2'd0, 2'd0, 4'd1, 4'd2, 4'd3));
      gap();
      // condition register copied out, store only happens when it is set
      put(enc(OP_MV, 2'd1, 2'd0, 2'd0, 4'd4, 4'd1, 4'd0));
      gap();
      c          = cmp_ref(e.op, a, bv);
      exp        = c ? 32'hFFFF_FFFF : fill(e.daddr);
      exp_writes = c ? 32'd1 : 32'd0;
    end
    put(enc(OP_HALT, 2'd0, 2'd0, 2'd0, 4'd0, 4'd0, 4'd0));
    put(NOP_WORD);
    put(NOP_WORD);
    @(negedge clk);
    count0 = write_count;
    resume = 1'b1;
    @(negedge clk);
    resume = 1'b0;
    wait_run();
    repeat (4) @(negedge clk);
    check(32'(write_count - count0), exp_writes, "data write count");
    check(ram[e.daddr], exp, "RAM result word");
  endtask

  initial
  begin
    table_q[0]  = '{OP_ADD,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h10};
    table_q[1]  = '{OP_SUB,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h14};
    table_q[2]  = '{OP_AND,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h18};
    table_q[3]  = '{OP_OR,   1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h1C};
    table_q[4]  = '{OP_XOR,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h20};
    table_q[5]  = '{OP_NOT,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h24};
    table_q[6]  = '{OP_SR,   1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h28};
    table_q[7]  = '{OP_SL,   1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h2C};
    table_q[8]  = '{OP_SRA,  1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 8'h30};
    table_q[9]  = '{OP_CEQ,  1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 8'h34};
    table_q[10] = '{OP_CEQ,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h38};
    // negative a against positive b splits unsigned from signed
    table_q[11] = '{OP_CGT,  1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 8'h3C};
    table_q[12] = '{OP_CGTA, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 8'h40};
    table_q[13] = '{OP_CGT,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h44};
    table_q[14] = '{OP_CGTA, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h48};
    table_q[15] = '{OP_ADD,  1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 8'h4C};
    table_q[16] = '{OP_SUB,  1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 8'h50};
    for (int i = 0; i < 256; i++)
    begin
      rom[i] = NOP_WORD;
      ram[i] = fill(8'(i));
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check({31'd0, stopped}, 32'd1, "stopped after reset");
    check({31'd0, mem_d_we}, 32'd0, "mem_d_we after reset");
    check({24'd0, mem_i_addr_r}, 32'd0, "instruction address after reset");
    check({24'd0, mem_d_addr_r_a}, 32'd0, "read address a after reset");
    check({24'd0, mem_d_addr_r_b}, 32'd0, "read address b after reset");
    check({24'd0, mem_d_addr_w}, 32'd0, "write address after reset");
    repeat (5) @(negedge clk);
    check(32'(write_count), 32'd0, "writes before resume");
    for (int i = 0; i < N_ENTRIES; i++)
      run_entry(table_q[i]);
    $display("** PASS **");
    $finish;
  end

endmodule

//--- sc1.f
sc1_pkg.sv
sc1_exec_if.sv
sc1_fetch.sv
sc1_regfile.sv
sc1_addr_gen.sv
sc1_execute.sv
sc1_cpu.sv
sc1_assert.sv
tb_sc1.sv

//--- Makefile
# Verilator build and run for the sc1 testbench

VERILATOR ?= verilator
TOP       ?= tb_sc1
FLIST     ?= sc1.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
